// ==== bench/fpx_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "fpx_consts.svh"

module fpx_properties (
	input logic                  _0_f,
	input logic                  wc_s,
	input fpx_bus_pkg::apb_req_t req,
	input fpx_bus_pkg::apb_rsp_t rsp,
	input logic                  busy,
	input logic                  finish,
	input logic                  shift_step
);

	// failure tally per rule, summed for the testbench
	int fail_pready = 0;
	int fail_step = 0;
	int fail_overlap = 0;
	int fail_slverr = 0;
	int fail_total;

	assign fail_total = fail_pready + fail_step + fail_overlap + fail_slverr;

	a_pready: assert property (@(posedge _0_f) disable iff (wc_s) rsp.pready)
		else begin
			fail_pready = fail_pready + 1;
			$error("pready low");
		end

	a_step_busy: assert property (@(posedge _0_f) disable iff (wc_s) shift_step |-> busy)
		else begin
			fail_step = fail_step + 1;
			$error("shift_step without busy");
		end

	a_no_overlap: assert property (@(posedge _0_f) disable iff (wc_s) !(finish && shift_step))
		else begin
			fail_overlap = fail_overlap + 1;
			$error("finish together with shift_step");
		end

	// error response only for a refused command
	a_slverr: assert property (@(posedge _0_f) disable iff (wc_s) rsp.pslverr |->
		(req.psel && req.penable && req.pwrite && req.paddr == `FPX_REG_CMD && busy))
		else begin
			fail_slverr = fail_slverr + 1;
			$error("pslverr outside a busy command write");
		end

endmodule

bind fpx_top fpx_properties u_props (
	._0_f       (_0_f),
	.wc_s       (wc_s),
	.req        (req),
	.rsp        (rsp),
	.busy       (busy),
	.finish     (finish),
	.shift_step (shift_step)
);

`default_nettype wire

// ==== bench/fpx_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "fpx_consts.svh"

module fpx_tb;

	localparam int NROWS      = 14;
	localparam int RST_CYCLES = 8;
	localparam int LIMIT      = NROWS * 60 + RST_CYCLES;

	typedef struct packed {
		fpx_arith_pkg::fp_op_t     op;
		fpx_arith_pkg::fp_exp_t    ea;
		fpx_arith_pkg::fp_exp_t    eb;
		fpx_arith_pkg::fp_exp_t    exp;
		fpx_arith_pkg::fp_shift_t  shift;
		fpx_arith_pkg::fp_status_t stat;
		logic                      collide;  // second command during alignment
	} row_t;

	logic                  _0_f = 1'b0;
	logic                  wc_s = 1'b1;
	fpx_bus_pkg::apb_req_t req = '0;
	fpx_bus_pkg::apb_rsp_t rsp;
	logic                  irq;
	logic                  shift_step;
	row_t                  rows [NROWS];
	int                    errors = 0;
	int                    checks = 0;
	int                    step_total = 0;
	int                    cycles = 0;

	fpx_top UUT (
		._0_f       (_0_f),
		.wc_s       (wc_s),
		.req        (req),
		.rsp        (rsp),
		.irq        (irq),
		.shift_step (shift_step)
	);

	always #4 _0_f = ~_0_f;

	// shift_step pulses seen so far
	always @(posedge _0_f) begin
		if (shift_step)
			step_total <= step_total + 1;
	end

	// watchdog
	always @(posedge _0_f) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// APB driver and compare tasks
	// ------------------------------------------------------------------

	// two-cycle access with read data taken at the access phase negedge
	task automatic apb_access(input logic wr, input logic [`FPX_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge _0_f);
		#1;
		req.paddr  = addr;
		req.pwdata = wdata;
		req.pwrite = wr;
		req.psel   = 1'b1;
		@(posedge _0_f);
		#1;
		req.penable = 1'b1;
		@(negedge _0_f);
		rdata = rsp.prdata;
		err   = rsp.pslverr;
		@(posedge _0_f);
		#1;
		req.psel    = 1'b0;
		req.penable = 1'b0;
	endtask

	task automatic check_exp(input string what, input fpx_arith_pkg::fp_exp_t got,
			input fpx_arith_pkg::fp_exp_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_shift(input string what, input fpx_arith_pkg::fp_shift_t got,
			input fpx_arith_pkg::fp_shift_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_status(input string what, input fpx_arith_pkg::fp_status_t got,
			input fpx_arith_pkg::fp_status_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// status bits from busy down to unf
	task automatic load_table();
		rows[0]  = '{fpx_arith_pkg::AF, 8'sd5, 8'sd2, 8'sd5, 6'd3, 6'b010000, 1'b0};
		rows[1]  = '{fpx_arith_pkg::AF, -8'sd3, 8'sd4, 8'sd4, 6'd7, 6'b010100, 1'b0};
		rows[2]  = '{fpx_arith_pkg::AF, -8'sd20, 8'sd19, 8'sd19, 6'd39, 6'b010100, 1'b0};
		rows[3]  = '{fpx_arith_pkg::SF, 8'sd20, -8'sd19, 8'sd20, 6'd39, 6'b010000, 1'b0};
		rows[4]  = '{fpx_arith_pkg::SF, 8'sd50, 8'sd10, 8'sd50, 6'd0, 6'b011000, 1'b0};
		rows[5]  = '{fpx_arith_pkg::SF, -8'sd60, 8'sd40, 8'sd40, 6'd0, 6'b011100, 1'b0};
		rows[6]  = '{fpx_arith_pkg::MF, 8'sd100, 8'sd50, -8'sd106, 6'd0, 6'b010010, 1'b0};
		rows[7]  = '{fpx_arith_pkg::MF, 8'sd60, 8'sd50, 8'sd110, 6'd0, 6'b010000, 1'b0};
		rows[8]  = '{fpx_arith_pkg::MF, -8'sd100, -8'sd40, 8'sd116, 6'd0, 6'b010001, 1'b0};
		rows[9]  = '{fpx_arith_pkg::MF, 8'sd3, 8'sd4, 8'sd7, 6'd0, 6'b010000, 1'b0};
		rows[10] = '{fpx_arith_pkg::DF, 8'sd10, 8'sd20, -8'sd10, 6'd0, 6'b010000, 1'b0};
		rows[11] = '{fpx_arith_pkg::DF, 8'sd100, -8'sd50, -8'sd106, 6'd0, 6'b010010, 1'b0};
		rows[12] = '{fpx_arith_pkg::DF, -8'sd120, 8'sd20, 8'sd116, 6'd0, 6'b010001, 1'b0};
		rows[13] = '{fpx_arith_pkg::SF, 8'sd30, -8'sd5, 8'sd30, 6'd35, 6'b010000, 1'b1};
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------

	initial begin
		row_t                      r;
		logic [31:0]               rd;
		logic                      err;
		int                        errs_before;
		int                        steps_before;
		fpx_arith_pkg::fp_status_t st;

		load_table();
		repeat (RST_CYCLES) @(posedge _0_f);
		#1;
		wc_s = 1'b0;

		// idle state straight after reset
		apb_access(1'b0, `FPX_REG_STAT, '0, rd, err);
		check_status("status after reset", rd[5:0], '0);
		check_flag("irq after reset", irq, 1'b0);

		for (int i = 0; i < NROWS; i++) begin
			r = rows[i];
			errs_before = errors;
			apb_access(1'b1, `FPX_REG_OPND, {16'd0, r.eb, r.ea}, rd, err);
			check_flag("pslverr on operand write", err, 1'b0);
			steps_before = step_total;
			apb_access(1'b1, `FPX_REG_CMD, {29'd0, r.op}, rd, err);
			check_flag("pslverr on command write", err, 1'b0);
			if (r.collide) begin
				apb_access(1'b1, `FPX_REG_CMD, {29'd0, fpx_arith_pkg::MF}, rd, err);
				check_flag("pslverr on command while busy", err, 1'b1);
				// running operation still visible in status
				apb_access(1'b0, `FPX_REG_STAT, '0, rd, err);
				st = rd[5:0];
				check_flag("busy during alignment", st.busy, 1'b1);
				check_flag("done during alignment", st.done, 1'b0);
			end
			// poll until done
			st = '0;
			while (!st.done) begin
				apb_access(1'b0, `FPX_REG_STAT, '0, rd, err);
				st = rd[5:0];
			end
			check_flag("irq with done", irq, 1'b1);
			check_shift("shift_step count",
				fpx_arith_pkg::fp_shift_t'(step_total - steps_before), r.shift);
			check_status("status", st, r.stat);
			apb_access(1'b0, `FPX_REG_RES, '0, rd, err);
			check_exp("exp", rd[7:0], r.exp);
			check_shift("shift field", rd[13:8], r.shift);
			// clear pulse lands one cycle after the write
			apb_access(1'b1, `FPX_REG_STAT, '0, rd, err);
			@(posedge _0_f);
			#1;
			check_flag("irq after clear", irq, 1'b0);
			$display("test %0d %s ea=%0d eb=%0d: %s", i, r.op.name(), r.ea, r.eb,
				(errors == errs_before) ? "ok" : "wrong");
		end

		if (UUT.u_props.fail_total != 0) begin
			$display("%0d assertion failures", UUT.u_props.fail_total);
			errors += UUT.u_props.fail_total;
		end
		$display("tests %0d, checks %0d, errors %0d", NROWS, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/fpx_apb_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "fpx_consts.svh"

module fpx_apb_regs (
	input  logic                   _0_f,
	input  logic                   wc_s,
	input  fpx_bus_pkg::apb_req_t  req,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   busy,
	output fpx_arith_pkg::fp_cmd_t cmd,
	output logic                   start,
	output logic                   stat_clr
);

	logic wr_acc;
	logic opnd_wr;
	logic cmd_wr;
	logic stat_wr;

	// ------------------------------------------------------------------
	// write decode
	// ------------------------------------------------------------------

	// accepted write, access phase only
	assign wr_acc  = req.psel & req.penable & req.pwrite;
	assign opnd_wr = wr_acc & (req.paddr == `FPX_REG_OPND);
	assign cmd_wr  = wr_acc & (req.paddr == `FPX_REG_CMD);
	assign stat_wr = wr_acc & (req.paddr == `FPX_REG_STAT);

	// zero wait states
	assign pready = 1'b1;

	// one operation at a time, a second command bounces
	assign pslverr = cmd_wr & busy;

	// ------------------------------------------------------------------
	// start and clear pulses
	// ------------------------------------------------------------------

	always_ff @(posedge _0_f or posedge wc_s) begin
		if (wc_s) begin
			start    <= 1'b0;
			stat_clr <= 1'b0;
		end else begin
			start    <= cmd_wr & ~busy;
			stat_clr <= stat_wr;
		end
	end

	// operand and opcode holding registers
	always_ff @(posedge _0_f) begin
		if (opnd_wr) begin
			cmd.ea <= req.pwdata[`FPX_EXP_W-1:0];
			cmd.eb <= req.pwdata[2*`FPX_EXP_W-1:`FPX_EXP_W];
		end
		if (cmd_wr && !busy) begin
			cmd.op <= fpx_arith_pkg::fp_op_t'(req.pwdata[2:0]);
		end
	end

endmodule

`default_nettype wire

// ==== design/fpx_arith_pkg.sv ====
`default_nettype none

`include "fpx_consts.svh"

package fpx_arith_pkg;

	// floating operations, coded as the ir[7:9] decoder outputs
	// codes 0..3 are the fixed-point group, not handled here
	typedef enum logic [2:0] {
		AF = 3'd4,
		SF = 3'd5,
		MF = 3'd6,
		DF = 3'd7
	} fp_op_t;

	typedef logic signed [`FPX_EXP_W-1:0] fp_exp_t;
	typedef logic [`FPX_SHIFT_W-1:0]      fp_shift_t;

	// ------------------------------------------------------------------
	// transfer records between the three parts
	// ------------------------------------------------------------------

	typedef struct packed {
		fp_op_t  op;
		fp_exp_t ea;
		fp_exp_t eb;
	} fp_cmd_t;

	typedef struct packed {
		fp_exp_t   exp;
		fp_shift_t shift;
		logic      g;    // difference at least 40
		logic      wdt;  // A is the smaller operand
		logic      ovf;
		logic      unf;
	} fp_res_t;

	// status register, bit 5 down to bit 0
	typedef struct packed {
		logic busy;
		logic done;
		logic g;
		logic wdt;
		logic ovf;
		logic unf;
	} fp_status_t;

endpackage

`default_nettype wire

// ==== design/fpx_bus_pkg.sv ====
`default_nettype none

`include "fpx_consts.svh"

package fpx_bus_pkg;

	// ------------------------------------------------------------------
	// APB slave side
	// ------------------------------------------------------------------

	// host request, one access phase
	typedef struct packed {
		logic [`FPX_ADDR_W-1:0] paddr;
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [31:0]            pwdata;
	} apb_req_t;

	// slave response
	// pready and pslverr come from the input side, prdata from the output side
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// ==== design/fpx_consts.svh ====
`ifndef FPX_CONSTS_SVH
`define FPX_CONSTS_SVH

// exponent datapath widths
`define FPX_EXP_W    8
`define FPX_EXT_W    10
`define FPX_SHIFT_W  6

// mantissa length, also the alignment limit
`define FPX_MANT_W   40

// APB register map
`define FPX_ADDR_W   4
`define FPX_REG_OPND 4'h0
`define FPX_REG_CMD  4'h4
`define FPX_REG_RES  4'h8
`define FPX_REG_STAT 4'hC

`endif

// ==== design/fpx_exp_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "fpx_consts.svh"

module fpx_exp_alu (
	input  logic                   _0_f,
	input  logic                   wc_s,
	input  fpx_arith_pkg::fp_cmd_t cmd,
	input  logic                   start,
	output fpx_arith_pkg::fp_res_t res,
	output logic                   busy,
	output logic                   finish,
	output logic                   shift_step
);

	logic                     align_op;
	logic                     sub;
	logic [`FPX_EXT_W-1:0]    a_ext;
	logic [`FPX_EXT_W-1:0]    b_ext;
	logic [`FPX_EXT_W-1:0]    b_bus;
	logic [`FPX_EXT_W-1:0]    sum;
	logic [`FPX_EXT_W-1:0]    mag;
	logic                     ge_40;
	fpx_arith_pkg::fp_res_t   res_d;
	fpx_arith_pkg::fp_shift_t cnt;

	// AF and SF go through alignment, MF and DF through range check
	assign align_op = (cmd.op != fpx_arith_pkg::MF) && (cmd.op != fpx_arith_pkg::DF);
	assign sub      = (cmd.op != fpx_arith_pkg::MF);

	// ------------------------------------------------------------------
	// extended exponent adder, two extra sign positions
	// ------------------------------------------------------------------

	assign a_ext = {{(`FPX_EXT_W-`FPX_EXP_W){cmd.ea[`FPX_EXP_W-1]}}, cmd.ea};
	assign b_ext = {{(`FPX_EXT_W-`FPX_EXP_W){cmd.eb[`FPX_EXP_W-1]}}, cmd.eb};

	// B bus inverted for subtract, carry-in completes the two's complement
	assign b_bus = sub ? ~b_ext : b_ext;
	assign sum   = a_ext + b_bus + `FPX_EXT_W'(sub);

	// magnitude of the difference
	assign mag   = sum[`FPX_EXT_W-1] ? (~sum + 1'b1) : sum;
	assign ge_40 = (mag >= `FPX_MANT_W);

	always_comb begin
		res_d     = '0;
		res_d.exp = sum[`FPX_EXP_W-1:0];
		if (align_op) begin
			res_d.wdt   = sum[`FPX_EXT_W-1];
			res_d.g     = ge_40;
			// larger exponent survives
			res_d.exp   = sum[`FPX_EXT_W-1] ? cmd.eb : cmd.ea;
			res_d.shift = ge_40 ? '0 : mag[`FPX_SHIFT_W-1:0];
		end else begin
			// bits above the 8-bit range must all equal the sign
			res_d.ovf = ~sum[`FPX_EXT_W-1] & (sum[`FPX_EXT_W-2:`FPX_EXP_W-1] != 2'b00);
			res_d.unf = sum[`FPX_EXT_W-1] & (sum[`FPX_EXT_W-2:`FPX_EXP_W-1] != 2'b11);
		end
	end

	// ------------------------------------------------------------------
	// alignment counter
	// ------------------------------------------------------------------

	always_ff @(posedge _0_f or posedge wc_s) begin
		if (wc_s) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt  <= res_d.shift;
		end else if (busy) begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			else
				busy <= 1'b0;
		end
	end

	always_ff @(posedge _0_f) begin
		if (start)
			res <= res_d;
	end

	// one step per remaining position, then a single finish cycle
	assign shift_step = busy & (cnt != '0);
	assign finish     = busy & (cnt == '0);

endmodule

`default_nettype wire

// ==== design/fpx_flag_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "fpx_consts.svh"

module fpx_flag_unit (
	input  logic                   _0_f,
	input  logic                   wc_s,
	input  fpx_arith_pkg::fp_res_t res,
	input  logic                   finish,
	input  logic                   busy,
	input  logic                   stat_clr,
	input  logic [`FPX_ADDR_W-1:0] paddr,
	output logic [31:0]            prdata,
	output logic                   irq
);

	logic                      done;
	logic                      busy_q;
	fpx_arith_pkg::fp_res_t    held;
	fpx_arith_pkg::fp_status_t stat;

	// ------------------------------------------------------------------
	// result capture and done flag
	// ------------------------------------------------------------------

	always_ff @(posedge _0_f or posedge wc_s) begin
		if (wc_s) begin
			done   <= 1'b0;
			busy_q <= 1'b0;
			held   <= '0;
		end else begin
			busy_q <= busy;
			if (finish) begin
				done <= 1'b1;
				held <= res;
			end else if (stat_clr || (busy && !busy_q)) begin
				// host acknowledge, or a new operation under way
				done <= 1'b0;
			end
		end
	end

	assign irq = done;

	always_comb begin
		stat.busy = busy;
		stat.done = done;
		stat.g    = held.g;
		stat.wdt  = held.wdt;
		stat.ovf  = held.ovf;
		stat.unf  = held.unf;
	end

	// read mux, combinational in the access phase
	always_comb begin
		case (paddr)
			`FPX_REG_RES:  prdata = {{(32-`FPX_SHIFT_W-`FPX_EXP_W){1'b0}}, held.shift, held.exp};
			`FPX_REG_STAT: prdata = {{(32-$bits(stat)){1'b0}}, stat};
			default:       prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/fpx_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module fpx_top (
	input  logic                  _0_f,
	input  logic                  wc_s,
	input  fpx_bus_pkg::apb_req_t req,
	output fpx_bus_pkg::apb_rsp_t rsp,
	output logic                  irq,
	output logic                  shift_step
);

	fpx_arith_pkg::fp_cmd_t cmd;
	fpx_arith_pkg::fp_res_t res;
	logic                   start;
	logic                   finish;
	logic                   busy;
	logic                   stat_clr;
	logic                   pready;
	logic                   pslverr;
	logic [31:0]            prdata;

	// response assembled from both register sides
	assign rsp = '{prdata: prdata, pready: pready, pslverr: pslverr};

	fpx_apb_regs u_regs (
		._0_f     (_0_f),
		.wc_s     (wc_s),
		.req      (req),
		.pready   (pready),
		.pslverr  (pslverr),
		.busy     (busy),
		.cmd      (cmd),
		.start    (start),
		.stat_clr (stat_clr)
	);

	fpx_exp_alu u_alu (
		._0_f       (_0_f),
		.wc_s       (wc_s),
		.cmd        (cmd),
		.start      (start),
		.res        (res),
		.busy       (busy),
		.finish     (finish),
		.shift_step (shift_step)
	);

	fpx_flag_unit u_flags (
		._0_f     (_0_f),
		.wc_s     (wc_s),
		.res      (res),
		.finish   (finish),
		.busy     (busy),
		.stat_clr (stat_clr),
		.paddr    (req.paddr),
		.prdata   (prdata),
		.irq      (irq)
	);

endmodule

`default_nettype wire

// ==== fpx_top.f ====
+incdir+design
design/fpx_bus_pkg.sv
design/fpx_arith_pkg.sv
design/fpx_apb_regs.sv
design/fpx_exp_alu.sv
design/fpx_flag_unit.sv
design/fpx_top.sv
bench/fpx_properties.sv
bench/fpx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fpx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fpx_tb -f fpx_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vfpx_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^SIMULATION PASSED$'; then
	exit 0
fi
echo "pass message not found"
exit 1
